/* common/ioexp_pkg.sv */
`default_nettype none

package ioexp_pkg;

    // One SPI frame, sent MSB first
    typedef struct packed {
        logic       rw;
        logic [6:0] addr;
        logic [7:0] data;
    } spi_frame_t;

    // Expander register addresses
    typedef enum logic [6:0] {
        op_port0    = 7'h00,
        op_port1    = 7'h01,
        op_port2    = 7'h02,
        op_port3    = 7'h03,
        op_port4    = 7'h04,
        op_port5    = 7'h05,
        op_port6    = 7'h06,
        op_port7    = 7'h07,
        op_port8    = 7'h08,
        op_port9    = 7'h09,
        op_config   = 7'h0a,
        op_p30_all  = 7'h0b,
        op_p74_all  = 7'h0c,
        op_read_p70 = 7'h0e,
        op_read_p98 = 7'h0f,
        op_nop      = 7'h20
    } ioexp_op_e;

    // Sequencer phases
    typedef enum logic [2:0] {
        cfg_check,
        idle,
        poll,
        output_upd,
        host_io
    } seq_phase_e;

    // Host request toward the sequencer
    typedef struct packed {
        logic       valid;
        logic       clear_errors;
        logic       debug_sel;
        spi_frame_t frame;
    } host_cmd_t;

    // Sequencer state reported to the host side
    typedef struct packed {
        logic       cfg_present;
        logic       read_error;
        logic [7:0] error_mask;
        logic [7:0] error_count;
        logic [7:0] outputs_fb;
        logic [7:0] requested;
        logic       host_pending;
        logic       host_read;
    } ioexp_status_t;

    // Host register address of the expander
    localparam logic [15:0] reg_io_exp_addr = 16'h000e;

    // Idle cycles between polls
    localparam logic [5:0] poll_interval = 6'd63;

    // Frame timing of the shifter
    localparam logic [5:0] cs_hold_cycles = 6'd2;
    localparam logic [5:0] shift_last = 6'h22;

    // Fixed command frames
    localparam logic [15:0] cfg_frame = {1'b0, op_config, 8'h01};
    localparam logic [15:0] nop_frame = {1'b0, op_nop, 8'h00};

endpackage

`default_nettype wire

/* hdl/ioexp_spi_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_spi_shifter (
    input  logic                  clk,
    input  logic                  ioexp_cfg_reset,
    input  logic                  start,
    input  ioexp_pkg::spi_frame_t tx_frame,
    output logic                  done,
    output ioexp_pkg::spi_frame_t rx_frame,
    input  logic                  miso,
    output logic                  mosi,
    output logic                  sclk,
    output logic                  csn,
    input  logic                  other_busy,
    output logic                  this_busy
);

    // Sequence count, two counts per bit
    logic [5:0] seqn;
    // Frame in progress
    logic       active;
    // Shift window, csn released after this
    logic       in_window;
    logic [3:0] tx_idx;
    logic [3:0] rx_idx;
    ioexp_pkg::spi_frame_t tx_q;
    ioexp_pkg::spi_frame_t rx_q;

    //   seqn   0  1   2   3   4   5
    //   sclk   ___|---|___|---|___|---
    //   mosi  15     14      13
    // Next bit goes out as sclk falls
    assign tx_idx = ~(seqn[4:1] + 4'd1);
    assign rx_idx = ~seqn[4:1];
    assign in_window = seqn < (ioexp_pkg::shift_last - ioexp_pkg::cs_hold_cycles);

    // Clock only runs while selected
    assign sclk = seqn[0] & ~csn;
    assign rx_frame = rx_q;

    always_ff @(posedge clk) begin
        if (ioexp_cfg_reset) begin
            active    <= 1'b0;
            seqn      <= 6'd0;
            csn       <= 1'b1;
            this_busy <= 1'b0;
            mosi      <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !active) begin
                active    <= 1'b1;
                seqn      <= 6'd0;
                // First bit ready before the first rising edge
                mosi      <= tx_frame[15];
                // Only select if the bus is free
                csn       <= other_busy;
                this_busy <= ~other_busy;
            end else if (active && !other_busy) begin
                this_busy <= 1'b1;
                seqn      <= seqn + 6'd1;
                if (seqn == ioexp_pkg::shift_last) begin
                    // Frame complete
                    active <= 1'b0;
                    csn    <= 1'b1;
                    seqn   <= 6'd0;
                    done   <= 1'b1;
                end else if (!in_window) begin
                    // Hold csn high for the closing cycles
                    csn <= 1'b1;
                end else begin
                    csn <= 1'b0;
                    if (seqn[0]) begin
                        mosi <= tx_q[tx_idx];
                    end
                end
            end else begin
                // Idle or paused by the other device
                csn       <= 1'b1;
                this_busy <= 1'b0;
            end
        end
    end

    // Frame data
    always_ff @(posedge clk) begin
        if (start && !active) begin
            tx_q <= tx_frame;
            rx_q <= '0;
        end else if (active && !other_busy && in_window) begin
            // Last write per bit lands while sclk is high
            rx_q[rx_idx] <= miso;
        end
    end

endmodule

`default_nettype wire

/* ioexp_seq/ioexp_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_sequencer (
    input  logic                     clk,
    input  logic                     ioexp_cfg_reset,
    input  logic [3:0]               p30,
    input  logic [3:0]               p74,
    output logic [1:0]               p98,
    output logic                     start,
    output ioexp_pkg::spi_frame_t    tx_frame,
    input  logic                     done,
    input  ioexp_pkg::spi_frame_t    rx_frame,
    input  ioexp_pkg::host_cmd_t     host_cmd,
    output logic                     host_taken,
    output ioexp_pkg::ioexp_status_t status,
    output logic [15:0]              read_saved
);

    ioexp_pkg::seq_phase_e phase;
    logic [3:0] step;
    logic [3:0] next_step;
    // Frame handed to the shifter, waiting for done
    logic       waiting;
    logic [5:0] poll_timer;
    logic       cfg_present;
    logic       read_error;
    logic [7:0] error_mask;
    logic [7:0] error_count;
    logic [7:0] outputs_fb;
    // Last value written to the expander ports
    logic [7:0] shadow;
    // Opcode of the last host frame, bit 7 set for a read
    logic [7:0] host_addr;
    logic [7:0] requested;
    logic       p30_changed;
    logic       p74_changed;
    logic       p30_same;
    logic       p74_same;
    logic [7:0] fb_diff;

    assign requested = {p74, p30};
    assign p30_changed = requested[3:0] != shadow[3:0];
    assign p74_changed = requested[7:4] != shadow[7:4];
    // Uniform nibble can go out as one frame
    assign p30_same = (requested[3:0] == 4'h0) || (requested[3:0] == 4'hf);
    assign p74_same = (requested[7:4] == 4'h0) || (requested[7:4] == 4'hf);
    assign fb_diff = rx_frame.data ^ shadow;

    assign status = '{
        cfg_present:  cfg_present,
        read_error:   read_error,
        error_mask:   error_mask,
        error_count:  error_count,
        outputs_fb:   outputs_fb,
        requested:    requested,
        host_pending: host_cmd.valid,
        host_read:    host_addr[7]
    };

    always_ff @(posedge clk) begin
        if (ioexp_cfg_reset) begin
            phase       <= ioexp_pkg::cfg_check;
            step        <= 4'd0;
            next_step   <= 4'd0;
            waiting     <= 1'b0;
            start       <= 1'b0;
            host_taken  <= 1'b0;
            poll_timer  <= 6'd0;
            cfg_present <= 1'b0;
            read_error  <= 1'b0;
            error_mask  <= 8'd0;
            error_count <= 8'd0;
            outputs_fb  <= 8'hff;
            shadow      <= 8'hff;
            host_addr   <= 8'd0;
            p98         <= 2'd0;
        end else begin
            start      <= 1'b0;
            host_taken <= 1'b0;
            if (start) begin
                waiting <= 1'b1;
            end

            if (waiting) begin
                if (done) begin
                    // Reply of the frame just finished
                    waiting <= 1'b0;
                    step    <= next_step;
                    if (phase == ioexp_pkg::cfg_check && step == 4'd1) begin
                        // Expander echoes the config frame during the nop
                        cfg_present <= rx_frame == ioexp_pkg::cfg_frame;
                    end
                    if (phase == ioexp_pkg::poll && step == 4'd1) begin
                        if ({rx_frame.rw, rx_frame.addr} == {1'b1, ioexp_pkg::op_read_p70}) begin
                            outputs_fb <= rx_frame.data;
                            error_mask <= fb_diff;
                            if (fb_diff != 8'd0) begin
                                error_count <= error_count + 8'd1;
                            end
                        end else begin
                            read_error <= 1'b1;
                        end
                    end
                    if (phase == ioexp_pkg::poll && step == 4'd2) begin
                        if ({rx_frame.rw, rx_frame.addr} == {1'b1, ioexp_pkg::op_read_p98}) begin
                            p98 <= rx_frame.data[1:0];
                        end else begin
                            read_error <= 1'b1;
                        end
                    end
                    // Host read reply shows up in a later frame
                    if (host_addr[7] && {rx_frame.rw, rx_frame.addr} == host_addr) begin
                        read_saved <= rx_frame;
                        host_addr  <= 8'd0;
                    end
                end
            end else if (!start) begin
                case (phase)
                    ioexp_pkg::cfg_check: begin
                        if (step == 4'd2) begin
                            phase <= ioexp_pkg::idle;
                            step  <= 4'd0;
                        end else begin
                            // All ports as inputs, then a nop to read the echo
                            tx_frame  <= step[0] ? ioexp_pkg::nop_frame : ioexp_pkg::cfg_frame;
                            start     <= 1'b1;
                            next_step <= step + 4'd1;
                        end
                    end
                    ioexp_pkg::idle: begin
                        step <= 4'd0;
                        if (cfg_present) begin
                            poll_timer <= poll_timer + 6'd1;
                        end else begin
                            error_mask <= 8'd0;
                        end
                        // Compare against the shadow, not the feedback,
                        // so a stuck port does not retrigger forever
                        if (cfg_present && requested != shadow) begin
                            phase <= ioexp_pkg::output_upd;
                        end else if (cfg_present && poll_timer == ioexp_pkg::poll_interval) begin
                            phase <= ioexp_pkg::poll;
                        end else if (host_cmd.valid) begin
                            phase <= ioexp_pkg::host_io;
                        end
                    end
                    ioexp_pkg::poll: begin
                        if (step == 4'd3) begin
                            phase      <= ioexp_pkg::idle;
                            step       <= 4'd0;
                            poll_timer <= 6'd0;
                        end else begin
                            case (step)
                                4'd0:    tx_frame <= {1'b1, ioexp_pkg::op_read_p70, 8'h00};
                                4'd1:    tx_frame <= {1'b1, ioexp_pkg::op_read_p98, 8'h00};
                                default: tx_frame <= ioexp_pkg::nop_frame;
                            endcase
                            start     <= 1'b1;
                            next_step <= step + 4'd1;
                        end
                    end
                    ioexp_pkg::output_upd: begin
                        // Steps 0-3 cover ports 0-3, steps 4-7 ports 4-7
                        if (step[3]) begin
                            phase      <= ioexp_pkg::idle;
                            step       <= 4'd0;
                            // Give outputs time to settle before the next check
                            poll_timer <= 6'd0;
                        end else if (step[2] ? p74_changed : p30_changed) begin
                            if (step == 4'd0 && p30_same) begin
                                tx_frame      <= {1'b0, ioexp_pkg::op_p30_all, 7'd0, requested[0]};
                                shadow[3:0]   <= requested[3:0];
                                start         <= 1'b1;
                                next_step     <= step + 4'd4;
                            end else if (step == 4'd4 && p74_same) begin
                                tx_frame      <= {1'b0, ioexp_pkg::op_p74_all, 7'd0, requested[4]};
                                shadow[7:4]   <= requested[7:4];
                                start         <= 1'b1;
                                next_step     <= step + 4'd4;
                            end else if (requested[step[2:0]] != shadow[step[2:0]]) begin
                                // Single port write, address equals port number
                                tx_frame <= {1'b0, 3'd0, step, 7'd0, requested[step[2:0]]};
                                shadow[step[2:0]] <= requested[step[2:0]];
                                start     <= 1'b1;
                                next_step <= step + 4'd1;
                            end else begin
                                step <= step + 4'd1;
                            end
                        end else begin
                            // Whole nibble already correct
                            step <= step + 4'd4;
                        end
                    end
                    ioexp_pkg::host_io: begin
                        if (step == 4'd0) begin
                            tx_frame   <= host_cmd.frame;
                            start      <= 1'b1;
                            host_taken <= 1'b1;
                            next_step  <= 4'd1;
                        end else begin
                            // Remember the opcode to catch the reply
                            host_addr <= {tx_frame.rw, tx_frame.addr};
                            phase     <= ioexp_pkg::idle;
                            step      <= 4'd0;
                        end
                    end
                    default: begin
                        phase <= ioexp_pkg::idle;
                    end
                endcase
            end

            // Host clear wins over a count in the same cycle
            if (host_cmd.clear_errors) begin
                read_error  <= 1'b0;
                error_count <= 8'd0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ioexp_host_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_host_regs #(
    parameter logic [3:0] ioexp_id = 4'd0
) (
    input  logic                     clk,
    input  logic                     ioexp_cfg_reset,
    input  logic [15:0]              reg_waddr,
    input  logic [31:0]              reg_wdata,
    input  logic                     reg_wen,
    output logic [31:0]              reg_rdata,
    output ioexp_pkg::host_cmd_t     host_cmd,
    input  logic                     host_taken,
    input  ioexp_pkg::ioexp_status_t status,
    input  logic [15:0]              read_saved,
    input  logic                     other_busy
);

    logic                  addr_hit;
    logic                  id_hit;
    // This expander was the one last addressed
    logic                  this_active;
    logic                  cmd_valid;
    logic                  clear_q;
    logic                  debug_q;
    ioexp_pkg::spi_frame_t frame_q;
    logic                  any_error;

    // Writes are dropped while a command is still queued
    assign addr_hit = reg_wen && (reg_waddr == ioexp_pkg::reg_io_exp_addr) && !cmd_valid;
    assign id_hit = reg_wdata[19:16] == ioexp_id;
    assign any_error = status.error_mask != 8'd0;

    assign host_cmd = '{
        valid:        cmd_valid,
        clear_errors: clear_q,
        debug_sel:    debug_q,
        frame:        frame_q
    };

    always_ff @(posedge clk) begin
        if (ioexp_cfg_reset) begin
            this_active <= 1'b0;
            cmd_valid   <= 1'b0;
            clear_q     <= 1'b0;
            debug_q     <= 1'b0;
        end else begin
            // Clear request is a single cycle
            clear_q <= 1'b0;
            if (host_taken) begin
                cmd_valid <= 1'b0;
            end
            if (addr_hit) begin
                this_active <= id_hit;
                if (id_hit) begin
                    clear_q <= reg_wdata[31];
                    debug_q <= reg_wdata[30];
                    // Frame only goes out when the control bits are clear
                    if (reg_wdata[31:20] == 12'd0) begin
                        cmd_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Queued expander frame
    always_ff @(posedge clk) begin
        if (addr_hit && id_hit && reg_wdata[31:20] == 12'd0) begin
            frame_q <= reg_wdata[15:0];
        end
    end

    // Read word, zero when another expander was addressed
    always_comb begin
        if (!this_active) begin
            reg_rdata = 32'd0;
        end else if (debug_q) begin
            reg_rdata = {status.error_mask, status.error_count,
                         status.outputs_fb, status.requested};
        end else begin
            reg_rdata = {3'b010, other_busy, status.host_read, status.host_pending,
                         status.read_error, any_error, status.error_mask, read_saved};
        end
    end

endmodule

`default_nettype wire

/* hdl/ioexp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_top #(
    parameter logic [3:0] ioexp_id = 4'd0
) (
    input  logic        clk,
    input  logic        ioexp_cfg_reset,
    // Host register port
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    output logic [31:0] reg_rdata,
    // Shared SPI bus
    input  logic        miso,
    output logic        mosi,
    output logic        sclk,
    output logic        csn,
    input  logic        other_busy,
    output logic        this_busy,
    // Expander port signals
    input  logic [3:0]  p30,
    input  logic [3:0]  p74,
    output logic [1:0]  p98,
    output logic        cfg_present,
    output logic [3:0]  p30_error,
    output logic [3:0]  p74_error
);

    logic                     start;
    logic                     done;
    logic                     host_taken;
    logic [15:0]              read_saved;
    ioexp_pkg::spi_frame_t    tx_frame;
    ioexp_pkg::spi_frame_t    rx_frame;
    ioexp_pkg::host_cmd_t     host_cmd;
    ioexp_pkg::ioexp_status_t status;

    assign cfg_present = status.cfg_present;
    assign p30_error = status.error_mask[3:0];
    assign p74_error = status.error_mask[7:4];

    ioexp_spi_shifter u_shifter (
        .clk             (clk),
        .ioexp_cfg_reset (ioexp_cfg_reset),
        .start           (start),
        .tx_frame        (tx_frame),
        .done            (done),
        .rx_frame        (rx_frame),
        .miso            (miso),
        .mosi            (mosi),
        .sclk            (sclk),
        .csn             (csn),
        .other_busy      (other_busy),
        .this_busy       (this_busy)
    );

    ioexp_sequencer u_sequencer (
        .clk             (clk),
        .ioexp_cfg_reset (ioexp_cfg_reset),
        .p30             (p30),
        .p74             (p74),
        .p98             (p98),
        .start           (start),
        .tx_frame        (tx_frame),
        .done            (done),
        .rx_frame        (rx_frame),
        .host_cmd        (host_cmd),
        .host_taken      (host_taken),
        .status          (status),
        .read_saved      (read_saved)
    );

    ioexp_host_regs #(
        .ioexp_id (ioexp_id)
    ) u_host_regs (
        .clk             (clk),
        .ioexp_cfg_reset (ioexp_cfg_reset),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .reg_rdata       (reg_rdata),
        .host_cmd        (host_cmd),
        .host_taken      (host_taken),
        .status          (status),
        .read_saved      (read_saved),
        .other_busy      (other_busy)
    );

endmodule

`default_nettype wire

/* dv/max7317_model.sv */
`timescale 1ns/100ps
`default_nettype none

module max7317_model (
    input  logic       rst,
    input  logic       sclk,
    input  logic       csn,
    input  logic       mosi,
    output logic       miso,
    // Device not fitted, miso floats high
    input  logic       absent,
    // Ports whose pull-up is missing read back low
    input  logic [7:0] stuck_mask,
    input  logic [1:0] in98,
    output logic [7:0] out_ports,
    output int         p30_all_cnt,
    output int         p74_all_cnt
);

    logic [15:0] rx_shift;
    logic [15:0] frame;
    // Reply shifted out during the next frame
    logic [15:0] reply;
    logic [4:0]  rise_cnt;
    logic        miso_q;

    initial begin
        out_ports   = 8'hff;
        reply       = 16'd0;
        rise_cnt    = 5'd0;
        miso_q      = 1'b1;
        p30_all_cnt = 0;
        p74_all_cnt = 0;
    end

    assign miso = absent ? 1'b1 : miso_q;

    always @(posedge sclk or posedge rst) begin
        if (rst) begin
            rise_cnt <= 5'd0;
        end else if (!csn) begin
            // Present the bit for this clock, held until the next rise
            miso_q   <= reply[4'd15 - rise_cnt[3:0]];
            frame    = {rx_shift[14:0], mosi};
            rx_shift <= frame;
            rise_cnt <= rise_cnt + 5'd1;
            if (rise_cnt == 5'd15) begin
                rise_cnt <= 5'd0;
                reply    <= frame;
                if (frame[15]) begin
                    // Reads return the opcode plus the port levels
                    if (frame[14:8] == ioexp_pkg::op_read_p70) begin
                        reply <= {frame[15:8], out_ports & ~stuck_mask};
                    end else if (frame[14:8] == ioexp_pkg::op_read_p98) begin
                        reply <= {frame[15:8], 6'd0, in98};
                    end
                end else if (!absent) begin
                    if (frame[14:8] < 7'h08) begin
                        out_ports[frame[10:8]] <= frame[0];
                    end else if (frame[14:8] == ioexp_pkg::op_p30_all) begin
                        out_ports[3:0] <= {4{frame[0]}};
                        p30_all_cnt    <= p30_all_cnt + 1;
                    end else if (frame[14:8] == ioexp_pkg::op_p74_all) begin
                        out_ports[7:4] <= {4{frame[0]}};
                        p74_all_cnt    <= p74_all_cnt + 1;
                    end
                    // Config and nop only echo
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/ioexp_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_chk (
    input logic clk,
    input logic ioexp_cfg_reset,
    input logic sclk,
    input logic csn,
    input logic mosi,
    input logic done,
    input logic other_busy,
    input logic this_busy
);

    // Clock edges only toward a selected device, and only while we own the bus
    sclk_with_csn: assert property (@(posedge clk) disable iff (ioexp_cfg_reset)
        sclk |-> (!csn && this_busy))
        else $error("sclk high while csn is high or the bus is not owned");

    // Other master claims the bus, so release it on the next cycle
    csn_yields: assert property (@(posedge clk) disable iff (ioexp_cfg_reset)
        other_busy |=> (csn && !this_busy))
        else $error("csn low while the other master holds the bus");

    // Data only moves on the falling edge
    mosi_stable: assert property (@(posedge clk) disable iff (ioexp_cfg_reset)
        sclk |-> $stable(mosi))
        else $error("mosi changed while sclk is high");

    done_deselects: assert property (@(posedge clk) disable iff (ioexp_cfg_reset)
        done |-> csn ##1 csn)
        else $error("csn not held high after the end of a frame");

endmodule

`default_nettype wire

/* dv/ioexp_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ioexp_tb;

    localparam int n_tests = 6;
    localparam int watchdog_ns = n_tests * 40 * 40 * 100;
    // One poll interval plus its three frames, rounded up
    localparam int poll_cycles = 200;
    // Idle stretch after which the outputs must have settled
    localparam int quiet_cycles = 63;

    logic        clk;
    logic        ioexp_cfg_reset;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic [31:0] reg_rdata;
    logic        miso;
    logic        mosi;
    logic        sclk;
    logic        csn;
    logic        other_busy;
    logic        this_busy;
    logic [3:0]  p30;
    logic [3:0]  p74;
    logic [1:0]  p98;
    logic        cfg_present;
    logic [3:0]  p30_error;
    logic [3:0]  p74_error;
    logic        absent;
    logic [7:0]  stuck_mask;
    logic [1:0]  in98;
    logic [7:0]  out_ports;
    int          p30_all_cnt;
    int          p74_all_cnt;
    int          seed;
    int          errors;

    ioexp_top #(.ioexp_id(4'd3)) dut (.*);

    max7317_model u_model (
        .rst         (ioexp_cfg_reset),
        .sclk        (sclk),
        .csn         (csn),
        .mosi        (mosi),
        .miso        (miso),
        .absent      (absent),
        .stuck_mask  (stuck_mask),
        .in98        (in98),
        .out_ports   (out_ports),
        .p30_all_cnt (p30_all_cnt),
        .p74_all_cnt (p74_all_cnt)
    );

    bind ioexp_spi_shifter ioexp_chk u_chk (
        .clk             (clk),
        .ioexp_cfg_reset (ioexp_cfg_reset),
        .sclk            (sclk),
        .csn             (csn),
        .mosi            (mosi),
        .done            (done),
        .other_busy      (other_busy),
        .this_busy       (this_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Inputs change and outputs are read 10 ns after the edge
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic fail_run(input string what);
        errors++;
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic check_nonzero(input string name, input logic [31:0] actual);
        assert (actual != 0) else begin
            errors++;
            $display("** Error: %s expected nonzero actual %h", name, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        ioexp_cfg_reset = 1'b1;
        tick(16);
        ioexp_cfg_reset = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] data);
        reg_waddr = ioexp_pkg::reg_io_exp_addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        tick(1);
        reg_wen   = 1'b0;
    endtask

    // Wait until this_busy has stayed low for n cycles
    task automatic wait_quiet(input int n);
        int quiet;
        int spent;
        quiet = 0;
        spent = 0;
        while (quiet < n) begin
            tick(1);
            spent++;
            quiet = this_busy ? 0 : quiet + 1;
            if (spent > 3000) fail_run("Timeout: SPI bus never went idle");
        end
    endtask

    task automatic wait_rdata_bit(input int idx, input logic val, input string what);
        int spent;
        spent = 0;
        while (reg_rdata[idx] !== val) begin
            tick(1);
            spent++;
            if (spent > 2000) fail_run(what);
        end
    endtask

    task automatic wait_present();
        int spent;
        spent = 0;
        while (!cfg_present && spent < 200) begin
            tick(1);
            spent++;
        end
        check_value("presence", 32'd1, cfg_present);
    endtask

    initial begin
        #watchdog_ns;
        $display("Timeout: run did not finish within %0d ns", watchdog_ns);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        int  rnd;
        int  cnt_before;
        seed            = 85396;
        errors          = 0;
        ioexp_cfg_reset = 1'b1;
        reg_waddr       = 16'd0;
        reg_wdata       = 32'd0;
        reg_wen         = 1'b0;
        other_busy      = 1'b0;
        p30             = 4'hf;
        p74             = 4'hf;
        absent          = 1'b0;
        stuck_mask      = 8'd0;
        in98            = 2'd0;

        // Presence, then an empty socket, then present again
        apply_reset();
        wait_present();
        absent = 1'b1;
        apply_reset();
        tick(200);
        check_value("absent", 32'd0, cfg_present);
        absent = 1'b0;
        apply_reset();
        wait_present();

        // Random output patterns
        repeat (4) begin
            rnd = $random(seed);
            p30 = rnd[3:0];
            p74 = rnd[7:4];
            wait_quiet(quiet_cycles);
            check_value("outputs", {24'd0, p74, p30}, out_ports);
        end
        // Uniform nibbles go out as one frame each
        cnt_before = p30_all_cnt;
        p30 = (p30 == 4'h0) ? 4'hf : 4'h0;
        wait_quiet(quiet_cycles);
        check_value("p30_all_frames", cnt_before + 1, p30_all_cnt);
        cnt_before = p74_all_cnt;
        p74 = (p74 == 4'h0) ? 4'hf : 4'h0;
        wait_quiet(quiet_cycles);
        check_value("p74_all_frames", cnt_before + 1, p74_all_cnt);
        check_value("uniform_outputs", {24'd0, p74, p30}, out_ports);

        // Input ports come back through the poll
        rnd  = $random(seed);
        // Kept away from the reset value of p98
        in98 = (rnd[1:0] == 2'd0) ? 2'd3 : rnd[1:0];
        tick(2 * poll_cycles);
        check_value("poll_p98", in98, p98);

        // Port 2 without pull-up
        p30 = 4'hf;
        p74 = 4'h3;
        stuck_mask = 8'h04;
        wait_quiet(quiet_cycles);
        tick(2 * poll_cycles);
        check_value("error_mask", 32'h04, {p74_error, p30_error});
        host_write(32'h4003_0000);
        check_value("debug_mask", 32'h04, reg_rdata[31:24]);
        check_value("debug_requested", 32'h3f, reg_rdata[7:0]);
        check_nonzero("debug_error_count", reg_rdata[23:16]);
        stuck_mask = 8'd0;
        tick(2 * poll_cycles);
        check_value("mask_after_repair", 32'd0, reg_rdata[31:24]);
        host_write(32'hc003_0000);
        tick(3);
        check_value("cleared_count", 32'd0, reg_rdata[23:16]);

        // Host read of ports 7 to 0, reply lands one frame later
        host_write(32'h0003_8e00);
        wait_rdata_bit(27, 1'b1, "Timeout: host read never issued");
        wait_rdata_bit(27, 1'b0, "Timeout: host read reply never captured");
        check_value("host_read", {16'd0, 8'h8e, out_ports}, reg_rdata[15:0]);
        host_write(32'h0005_0000);
        check_value("other_id_rdata", 32'd0, reg_rdata);

        // Other master grabs the bus mid-frame
        p30 = 4'b0110;
        rnd = 0;
        while (csn) begin
            tick(1);
            rnd++;
            if (rnd > 1000) fail_run("Timeout: no frame started for bus sharing");
        end
        tick(5);
        other_busy = 1'b1;
        tick(20);
        check_value("csn_released", 32'd1, csn);
        other_busy = 1'b0;
        wait_quiet(quiet_cycles);
        check_value("shared_outputs", {24'd0, p74, p30}, out_ports);

        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ioexp_top.f */
common/ioexp_pkg.sv
hdl/ioexp_spi_shifter.sv
ioexp_seq/ioexp_sequencer.sv
hdl/ioexp_host_regs.sv
hdl/ioexp_top.sv
dv/max7317_model.sv
dv/ioexp_chk.sv
dv/ioexp_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= ioexp_top.f
TOP       ?= ioexp_tb
LINT_TOP  ?= ioexp_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
